// File: fifo_flags.f
src/fifo_flags_pkg.sv
src/grey_sync.sv
src/fifo_write_flags.sv
src/fifo_read_flags.sv
src/fifo_flags.sv
+incdir+tb
tb/tb_fifo_flags.sv

// File: Bender.yml
package:
  name: fifo_flags

sources:
  - target: rtl
    files:
      - src/fifo_flags_pkg.sv
      - src/grey_sync.sv
      - src/fifo_write_flags.sv
      - src/fifo_read_flags.sv
      - src/fifo_flags.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_fifo_flags.sv

// File: tb/fifo_flags_model.svh
// occupancy model for the FIFO flag controller testbench
// accepted write and read counts, shadow storage array, data queue
// and the settled-flag check run after each idle gap

`ifndef FIFO_FLAGS_MODEL_SVH
`define FIFO_FLAGS_MODEL_SVH

  // accepted strobes since the last reset, the difference is the occupancy
  int writes_accepted;
  int reads_accepted;
  // stands in for the storage that sits outside the controller
  logic [31:0] shadow_mem [MAX_DEPTH];
  // words in the order they were captured
  logic [31:0] data_queue [$];

  function automatic int occupancy();
    return writes_accepted - reads_accepted;
  endfunction

  task automatic clear_model();
    writes_accepted = 0;
    reads_accepted  = 0;
    data_queue.delete();
  endtask

  // a capture writes a fresh word at the current write address
  task automatic record_write(input addr_t address);
    logic [31:0] word;
    word = $urandom;
    shadow_mem[address] = word;
    data_queue.push_back(word);
    writes_accepted++;
  endtask

  // the entry at the read address must be the oldest word still queued
  task automatic check_read_data(input addr_t address);
    if (data_queue.size() == 0)
    begin
      report_failure(3, "a remove was accepted while the model queue was empty");
    end
    else
    begin
      check_value(3, "shadow_mem[read address]", data_queue[0], shadow_mem[address]);
      void'(data_queue.pop_front());
      reads_accepted++;
    end
  endtask

  // both synchronizers have long settled, so the flags must be exact.
  // in flag-before-data mode the read enable follows the word count
  task automatic check_settled_flags(input int phase);
    repeat (SETTLE_CYCLES) @(posedge write_clk);
    #2;
    check_value(4, "read_status.data_available", occupancy() > 0,
                read_status.data_available);
    check_value(4, "read_status.two_words_available", occupancy() > 1,
                read_status.two_words_available);
    check_value(4, "write_status.room_available", occupancy() < DEPTH,
                write_status.room_available);
    check_value(4, "read_status.enable", occupancy() > 0, read_status.enable);
    $display("settled flags after phase %0d: occupancy %0d, %0d errors so far",
             phase, occupancy(), behavior_errors[4]);
  endtask

`endif

// File: tb/tb_fifo_flags.sv
// testbench for the asynchronous FIFO flag controller
// two free-running clocks, random fill, balanced and drain phases,
// checks against an occupancy model, reset checks and a watchdog

`timescale 1ns/1ps

module tb_fifo_flags
  import fifo_flags_pkg::*;
();

  localparam int unsigned DEPTH                  = 5;
  localparam bit          DOUBLE_SYNC_READ       = 1'b1;
  localparam bit          WRITE_DATA_BEFORE_FLAG = 1'b1;
  localparam bit          READ_FLAG_BEFORE_DATA  = 1'b1;
  localparam int PHASE_CYCLES    = 300;
  localparam int IDLE_CYCLES     = 20;
  localparam int SETTLE_CYCLES   = 4;
  localparam int WRITE_PERIOD_NS = 6;
  localparam int RESET_NS        = 16;
  localparam int RUN_NS =
    3 * (PHASE_CYCLES + IDLE_CYCLES + SETTLE_CYCLES) * WRITE_PERIOD_NS + RESET_NS;
  localparam int WATCHDOG_NS = RUN_NS + RUN_NS / 2;

  logic          reset_flags_async;
  logic          write_clk;
  logic          write_submit;
  logic          read_clk;
  logic          read_remove;
  write_status_t write_status;
  read_status_t  read_status;

  // per-behavior bookkeeping, 0 overflow 1 underflow 2 addresses
  // 3 data order 4 settled flags 5 reset state
  int   behavior_checks [6];
  int   behavior_errors [6];
  logic pending_write_error;
  logic pending_read_error;
  logic write_done;

  fifo_flags #(
    .DEPTH                  (DEPTH),
    .DOUBLE_SYNC_READ       (DOUBLE_SYNC_READ),
    .WRITE_DATA_BEFORE_FLAG (WRITE_DATA_BEFORE_FLAG),
    .READ_FLAG_BEFORE_DATA  (READ_FLAG_BEFORE_DATA)
  ) UUT (
    .reset_flags_async (reset_flags_async),
    .write_clk         (write_clk),
    .write_submit      (write_submit),
    .read_clk          (read_clk),
    .read_remove       (read_remove),
    .write_status      (write_status),
    .read_status       (read_status)
  );

  // read_clk rises on even ns, write_clk half a ns off so no sample
  // point of one side lands on the other side's edge
  initial
  begin
    read_clk = 1'b0;
    forever #2 read_clk = ~read_clk;
  end

  initial
  begin
    write_clk = 1'b0;
    #0.5;
    forever #3 write_clk = ~write_clk;
  end

  function automatic string behavior_name(input int id);
    case (id)
      0: return "no overflow";
      1: return "no underflow";
      2: return "addresses";
      3: return "data order";
      4: return "settled flags";
      default: return "reset state";
    endcase
  endfunction

  function automatic int total_errors();
    int sum;
    sum = 0;
    for (int i = 0; i < 6; i++)
    begin
      sum += behavior_errors[i];
    end
    return sum;
  endfunction

  task automatic check_value(input int id, input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    behavior_checks[id]++;
    if (actual !== expected)
    begin
      behavior_errors[id]++;
      $display("ERROR %s expected %h actual %h at time %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_failure(input int id, input string message);
    behavior_checks[id]++;
    behavior_errors[id]++;
    $display("%s at time %0t", message, $time);
  endtask

  `include "fifo_flags_model.svh"

  // ==========================================================================
  // one cycle on each side
  // ==========================================================================

  // registered outputs are checked 1 ns after the edge, the strobe is driven
  // there too and the same-cycle outputs are sampled 1 ns later
  task automatic write_cycle(input int unsigned submit_pct);
    @(posedge write_clk);
    #1;
    check_value(2, "write_status.address", writes_accepted % DEPTH, write_status.address);
    check_value(0, "write_status.error", pending_write_error, write_status.error);
    write_submit = ($urandom % 100) < submit_pct;
    #1;
    if (write_status.capture_data && occupancy() >= DEPTH)
    begin
      report_failure(0, "capture_data rose while the model FIFO was full");
    end
    pending_write_error = write_submit & ~write_status.capture_data;
    if (write_status.capture_data)
    begin
      record_write(write_status.address);
    end
  endtask

  task automatic read_cycle(input int unsigned remove_pct);
    @(posedge read_clk);
    #1;
    check_value(2, "read_status.address", reads_accepted % DEPTH, read_status.address);
    check_value(1, "read_status.error", pending_read_error, read_status.error);
    read_remove = ($urandom % 100) < remove_pct;
    #1;
    if (read_status.data_available && occupancy() == 0)
    begin
      report_failure(1, "data_available rose while the model FIFO was empty");
    end
    if (read_status.two_words_available && occupancy() < 2)
    begin
      report_failure(1, "two_words_available rose with fewer than two words stored");
    end
    pending_read_error = read_remove & ~read_status.data_available;
    if (read_remove && read_status.data_available)
    begin
      check_read_data(read_status.address);
    end
  endtask

  // ==========================================================================
  // phases and reset checks
  // ==========================================================================

  task automatic run_phase(input int number, input string name,
                           input int unsigned submit_pct, input int unsigned remove_pct);
    write_done = 1'b0;
    fork
      begin
        repeat (PHASE_CYCLES) write_cycle(submit_pct);
        write_done = 1'b1;
      end
      while (!write_done) read_cycle(remove_pct);
    join
    // idle gap lets the last strobes and errors drain out
    fork
      repeat (IDLE_CYCLES) write_cycle(0);
      repeat (IDLE_CYCLES) read_cycle(0);
    join
    check_settled_flags(number);
    $display("phase %0d %s done: %0d writes, %0d reads, %0d errors", number, name,
             writes_accepted, reads_accepted, total_errors());
  endtask

  task automatic check_reset_state(input string label);
    check_value(5, "write_status.room_available", 1'b1, write_status.room_available);
    check_value(5, "write_status.capture_data", 1'b0, write_status.capture_data);
    check_value(5, "write_status.error", 1'b0, write_status.error);
    check_value(5, "write_status.address", 0, write_status.address);
    check_value(5, "read_status.data_available", 1'b0, read_status.data_available);
    check_value(5, "read_status.two_words_available", 1'b0,
                read_status.two_words_available);
    check_value(5, "read_status.enable", !READ_FLAG_BEFORE_DATA, read_status.enable);
    check_value(5, "read_status.error", 1'b0, read_status.error);
    check_value(5, "read_status.address", 0, read_status.address);
    $display("reset state %s done: %0d errors so far", label, behavior_errors[5]);
  endtask

  // the pulse lands between clock edges, away from both domains
  task automatic pulse_reset();
    #0.7;
    reset_flags_async   = 1'b1;
    clear_model();
    pending_write_error = 1'b0;
    pending_read_error  = 1'b0;
    #1;
    check_reset_state("mid-run pulse");
    #1.5;
    reset_flags_async = 1'b0;
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the phases finished", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h79fe318c));
    reset_flags_async   = 1'b1;
    write_submit        = 1'b0;
    read_remove         = 1'b0;
    pending_write_error = 1'b0;
    pending_read_error  = 1'b0;
    write_done          = 1'b0;
    clear_model();
    repeat (4) @(posedge read_clk);
    #0.5;
    check_reset_state("initial reset");
    #0.5;
    reset_flags_async = 1'b0;

    run_phase(1, "fill-biased", 80, 20);
    pulse_reset();
    run_phase(2, "balanced", 50, 50);
    run_phase(3, "drain-biased", 20, 80);

    for (int i = 0; i < 6; i++)
    begin
      $display("%s: %0d checks, %0d errors", behavior_name(i), behavior_checks[i],
               behavior_errors[i]);
    end
    $display("total: %0d errors", total_errors());
    if (total_errors() == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src/fifo_flags.sv
// top level of the asynchronous FIFO flag controller
// write-side and read-side flag logic plus one Gray counter
// synchronizer in each direction

`timescale 1ns/1ps

module fifo_flags
  import fifo_flags_pkg::*;
#(
  parameter int unsigned DEPTH                  = 7,
  parameter bit          DOUBLE_SYNC_READ       = 1'b0,
  parameter bit          WRITE_DATA_BEFORE_FLAG = 1'b0,
  parameter bit          READ_FLAG_BEFORE_DATA  = 1'b0
)
(
  input  logic          reset_flags_async,
  input  logic          write_clk,
  input  logic          write_submit,
  input  logic          read_clk,
  input  logic          read_remove,
  output write_status_t write_status,
  output read_status_t  read_status
);

  // a fast write clock may need a second stage to settle the read counter
  localparam int unsigned WRITE_SYNC_STAGES = DOUBLE_SYNC_READ ? 2 : 1;
  // flag-before-data reads hold the write counter one more read cycle
  localparam int unsigned READ_SYNC_STAGES  = READ_FLAG_BEFORE_DATA ? 2 : 1;

  count_t write_count_out;
  count_t synced_write_count;
  count_t read_count_out;
  count_t synced_read_count;

  // ==========================================================================
  // write clock domain
  // ==========================================================================

  fifo_write_flags #(
    .DEPTH                  (DEPTH),
    .WRITE_DATA_BEFORE_FLAG (WRITE_DATA_BEFORE_FLAG)
  ) u_write_flags (
    .reset_flags_async (reset_flags_async),
    .write_clk         (write_clk),
    .write_submit      (write_submit),
    .synced_read_count (synced_read_count),
    .write_status      (write_status),
    .write_count_out   (write_count_out)
  );

  // read counter brought over to the write side
  grey_sync #(
    .STAGES (WRITE_SYNC_STAGES)
  ) u_read_count_sync (
    .reset_flags_async (reset_flags_async),
    .dest_clk          (write_clk),
    .count_in          (read_count_out),
    .count_out         (synced_read_count)
  );

  // ==========================================================================
  // read clock domain
  // ==========================================================================

  fifo_read_flags #(
    .DEPTH                 (DEPTH),
    .READ_FLAG_BEFORE_DATA (READ_FLAG_BEFORE_DATA)
  ) u_read_flags (
    .reset_flags_async  (reset_flags_async),
    .read_clk           (read_clk),
    .read_remove        (read_remove),
    .synced_write_count (synced_write_count),
    .read_status        (read_status),
    .read_count_out     (read_count_out)
  );

  // write counter brought over to the read side
  grey_sync #(
    .STAGES (READ_SYNC_STAGES)
  ) u_write_count_sync (
    .reset_flags_async (reset_flags_async),
    .dest_clk          (read_clk),
    .count_in          (write_count_out),
    .count_out         (synced_write_count)
  );

endmodule

// File: src/fifo_read_flags.sv
// read-clock half of the FIFO flag controller
// holds the read Gray counter and the storage read address,
// tests for empty and for two words available, flags underflow
// and drives the storage read enable

`timescale 1ns/1ps

module fifo_read_flags
  import fifo_flags_pkg::*;
#(
  parameter int unsigned DEPTH                 = 7,
  parameter bit          READ_FLAG_BEFORE_DATA = 1'b0
)
(
  input  logic         reset_flags_async,
  input  logic         read_clk,
  input  logic         read_remove,
  input  count_t       synced_write_count,
  output read_status_t read_status,
  output count_t       read_count_out
);

  count_t read_count;
  count_t next_read_count;
  addr_t  read_address;
  logic   read_error;
  logic   not_empty;
  logic   two_words;
  logic   read_enable;
  logic   accept;

  // ==========================================================================
  // empty and two-word tests
  // ==========================================================================

  // any difference between the counters means at least one word waits.
  // a stale write counter only makes empty show up early
  assign not_empty = (read_count != synced_write_count);

  // a second word is there if the FIFO would still not be empty
  // after the next remove
  assign next_read_count = grey_inc(read_count, DEPTH);
  assign two_words       = not_empty & (next_read_count != synced_write_count);

  // in flag-before-data mode the storage is only read once the flag is
  // seen, otherwise it is read all the time and data comes with the flag
  assign read_enable = READ_FLAG_BEFORE_DATA ? not_empty : 1'b1;

  // a remove only counts when a word is there
  assign accept = read_remove & not_empty;

  // ==========================================================================
  // counter, address and underflow error
  // ==========================================================================

  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      read_count   <= '0;
      read_address <= '0;
      read_error   <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        read_count   <= next_read_count;
        read_address <= addr_inc(read_address, DEPTH);
      end
      // a refused remove is reported for exactly one cycle
      read_error <= read_remove & ~not_empty;
    end
  end

  // the registered counter goes straight to the write-side synchronizer
  assign read_count_out = read_count;

  // data_available and two_words_available come from a freshly
  // synchronized counter and need extra settling margin downstream
  assign read_status = '{
    data_available:      not_empty,
    two_words_available: two_words,
    enable:              read_enable,
    error:               read_error,
    address:             read_address
  };

endmodule

// File: src/fifo_write_flags.sv
// write-clock half of the FIFO flag controller
// holds the write Gray counter and the storage write address,
// tests for full, flags overflow and drives the counter sent to the read side

`timescale 1ns/1ps

module fifo_write_flags
  import fifo_flags_pkg::*;
#(
  parameter int unsigned DEPTH                  = 7,
  parameter bit          WRITE_DATA_BEFORE_FLAG = 1'b0
)
(
  input  logic          reset_flags_async,
  input  logic          write_clk,
  input  logic          write_submit,
  input  count_t        synced_read_count,
  output write_status_t write_status,
  output count_t        write_count_out
);

  count_t write_count;
  count_t next_write_count;
  addr_t  write_address;
  logic   write_error;
  logic   not_full;
  logic   accept;

  // ==========================================================================
  // full test
  // ==========================================================================

  // the FIFO is full when one more write would make the write counter
  // catch up with the read counter.
  // the read counter seen here may be stale, which only makes full
  // show up early and never late
  assign next_write_count = grey_inc(write_count, DEPTH);
  assign not_full         = (next_write_count != synced_read_count);

  // a submit only counts when there is room for it
  assign accept = write_submit & not_full;

  // ==========================================================================
  // counter, address and overflow error
  // ==========================================================================

  always_ff @(posedge write_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      write_count   <= '0;
      write_address <= '0;
      write_error   <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        write_count   <= next_write_count;
        write_address <= addr_inc(write_address, DEPTH);
      end
      // a refused submit is reported for exactly one cycle
      write_error <= write_submit & ~not_full;
    end
  end

  // ==========================================================================
  // counter sent across to the read side
  // ==========================================================================

  generate
    if (WRITE_DATA_BEFORE_FLAG)
    begin : g_delayed
      // storage is written on the accept edge but the read side only
      // hears about it one cycle later, so the data is always in place
      // before data_available can rise
      count_t delayed_count;

      always_ff @(posedge write_clk or posedge reset_flags_async)
      begin
        if (reset_flags_async)
        begin
          delayed_count <= '0;
        end
        else
        begin
          delayed_count <= write_count;
        end
      end

      assign write_count_out = delayed_count;
    end
    else
    begin : g_direct
      // data and flag go out on the same edge
      assign write_count_out = write_count;
    end
  endgenerate

  // room_available and capture_data are same-cycle signals.
  // not_full is built from a freshly synchronized value, so it wants
  // generous setup margin to whatever logic consumes it
  assign write_status = '{
    room_available: not_full,
    capture_data:   accept,
    error:          write_error,
    address:        write_address
  };

endmodule

// File: src/grey_sync.sv
// synchronizer for a Gray occupancy counter crossing into another clock domain
// one or two register stages on the destination clock, asynchronous reset

`timescale 1ns/1ps

module grey_sync
  import fifo_flags_pkg::*;
#(
  // number of register stages, 1 or 2
  parameter int unsigned STAGES = 1
)
(
  input  logic   reset_flags_async,
  input  logic   dest_clk,
  input  count_t count_in,
  output count_t count_out
);

  // the first stage is the metastability boundary.
  // only one bit of the source counter moves per step, so whatever the
  // first stage settles to is either the old or the new counter value
  count_t stage_q [STAGES];

  always_ff @(posedge dest_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      for (int i = 0; i < STAGES; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= count_in;
      // a second stage buys a full extra cycle of settling time
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i - 1];
      end
    end
  end

  assign count_out = stage_q[STAGES - 1];

endmodule

// File: src/fifo_flags_pkg.sv
// shared types and helpers for the asynchronous FIFO flag controller
// count_t and addr_t, the write and read status structs,
// the Gray counter increment and the storage address increment

package fifo_flags_pkg;

  // largest FIFO depth the counters can describe
  parameter int unsigned MAX_DEPTH = 15;

  // Gray occupancy counter, equal read and write values mean empty
  typedef logic [3:0] count_t;

  // index of one storage entry, wraps modulo DEPTH
  typedef logic [3:0] addr_t;

  typedef struct packed {
    logic  room_available;
    logic  capture_data;
    logic  error;
    addr_t address;
  } write_status_t;

  typedef struct packed {
    logic  data_available;
    logic  two_words_available;
    logic  enable;
    logic  error;
    addr_t address;
  } read_status_t;

  // ==========================================================================
  // counter and address stepping
  // ==========================================================================

  // the counter has DEPTH+1 states, so one slot more than the storage.
  // depths 3, 7 and 15 use the full reflected code of 2, 3 or 4 bits.
  // depth 5 uses a 6-state truncated code that still steps one bit at a time
  function automatic count_t grey_inc(input count_t count, input int unsigned depth);
    count_t mask;
    count_t bin;
    count_t next_bin;
    mask = count_t'(depth);
    // convert to binary from the top bit down
    bin[3] = count[3];
    for (int i = 2; i >= 0; i--)
    begin
      bin[i] = bin[i + 1] ^ count[i];
    end
    next_bin = (bin + 4'd1) & mask;
    case (depth)
      3, 7, 15:
      begin
        // bits above the code width must stay clear
        if ((count & ~mask) != '0)
        begin
          return '0;
        end
        return next_bin ^ (next_bin >> 1);
      end
      5:
      begin
        case (count)
          4'b0000: return 4'b0001;
          4'b0001: return 4'b0011;
          4'b0011: return 4'b0010;
          4'b0010: return 4'b0110;
          4'b0110: return 4'b0100;
          4'b0100: return 4'b0000;
          default: return '0;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  // address counts 0 .. depth-1 and then wraps to 0
  function automatic addr_t addr_inc(input addr_t address, input int unsigned depth);
    if (address < addr_t'(depth - 1))
    begin
      return address + 4'd1;
    end
    return '0;
  endfunction

endpackage
